/* rtl/cntmem_pkg.sv */
`default_nettype none

package cntmem_pkg;

  localparam int PAR_MAX = 64;  // Widest word the parity helper accepts

  // Command a bank carries down its pipeline
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_COUNT = 2'd1,
    OP_HRD   = 2'd2,
    OP_HWR   = 2'd3
  } bank_op_t;

  typedef enum logic {
    ST_CLEAR = 1'b0,
    ST_RUN   = 1'b1
  } host_state_t;

  function automatic int bits_for(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Physical row width with one parity bit per word
  function automatic int row_width(input int width, input int nwrds);
    return nwrds * (width + 1);
  endfunction

  function automatic logic word_parity(input logic [PAR_MAX-1:0] w);
    return ^w;  // Even parity
  endfunction

endpackage

`default_nettype wire

/* rtl/word_align.sv */
`default_nettype none
`timescale 1ns/1ps

module word_align import cntmem_pkg::*; #(
  parameter int WIDTH = 16,
  parameter int NUMWRDS = 4,
  parameter int NUMSROW = 64,
  localparam int ADR_BITS = bits_for(NUMWRDS * NUMSROW),
  localparam int ROW_BITS = bits_for(NUMSROW),
  localparam int WRD_BITS = bits_for(NUMWRDS),
  localparam int MEM_W = WIDTH + 1,
  localparam int PHY_W = row_width(WIDTH, NUMWRDS)
) (
  input  logic [ADR_BITS-1:0] adr,
  input  logic [WIDTH-1:0]    wdata,
  input  logic [PHY_W-1:0]    row_data,
  output logic [ROW_BITS-1:0] row,
  output logic [PHY_W-1:0]    bw,
  output logic [PHY_W-1:0]    wrow,
  output logic [WIDTH-1:0]    rword,
  output logic                perr
);

  logic [WRD_BITS-1:0] wrd;
  logic [MEM_W-1:0]    wslot;
  logic [MEM_W-1:0]    rslot;

  assign row = ROW_BITS'(adr / NUMWRDS);
  assign wrd = WRD_BITS'(adr % NUMWRDS);

  // Parity sits above the data bits in each slot
  assign wslot = {word_parity(PAR_MAX'(wdata)), wdata};
  assign wrow  = PHY_W'(wslot) << (wrd * MEM_W);
  assign bw    = PHY_W'({MEM_W{1'b1}}) << (wrd * MEM_W);

  assign rslot = MEM_W'(row_data >> (wrd * MEM_W));
  assign rword = rslot[WIDTH-1:0];
  assign perr  = ^rslot;  // Nonzero on an odd number of flipped bits

endmodule

`default_nettype wire

/* rtl/counter_bank.sv */
`default_nettype none
`timescale 1ns/1ps

module counter_bank import cntmem_pkg::*; #(
  parameter int WIDTH = 16,
  parameter int NUMWRDS = 4,
  parameter int NUMSROW = 64,
  parameter int SRAM_DELAY = 2,
  parameter bit IS_FIRST = 1'b0,
  localparam int ADR_BITS = bits_for(NUMWRDS * NUMSROW),
  localparam int ROW_BITS = bits_for(NUMSROW),
  localparam int PHY_W = row_width(WIDTH, NUMWRDS)
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cnt,
  input  logic [ADR_BITS-1:0] ct_adr,
  input  logic [WIDTH-1:0]    imm,
  input  logic                host_rd,
  input  logic                host_wr,
  input  logic [ADR_BITS-1:0] host_adr,
  input  logic [WIDTH-1:0]    host_din,
  input  logic [ROW_BITS-1:0] clear_row,
  input  logic                clearing,
  input  logic [PHY_W-1:0]    bank_dout,
  output logic                ct_vld,
  output logic                ct_serr,
  output logic [WIDTH-1:0]    part_word,
  output logic                part_serr,
  output logic                bank_write,
  output logic [ROW_BITS-1:0] bank_wr_adr,
  output logic [PHY_W-1:0]    bank_bw,
  output logic [PHY_W-1:0]    bank_din,
  output logic                bank_read,
  output logic [ROW_BITS-1:0] bank_rd_adr
);

  bank_op_t            iss_op;
  logic [ADR_BITS-1:0] iss_adr;
  logic [WIDTH-1:0]    iss_val;

  bank_op_t            s_op  [1:SRAM_DELAY];
  logic [ADR_BITS-1:0] s_adr [1:SRAM_DELAY];
  logic [WIDTH-1:0]    s_val [1:SRAM_DELAY];

  // Recent writes with the newest in entry 1
  logic                h_vld  [1:SRAM_DELAY];
  logic                h_clr  [1:SRAM_DELAY];
  logic [ADR_BITS-1:0] h_adr  [1:SRAM_DELAY];
  logic [ROW_BITS-1:0] h_row  [1:SRAM_DELAY];
  logic [WIDTH-1:0]    h_data [1:SRAM_DELAY];

  bank_op_t            e_op;
  logic [ADR_BITS-1:0] e_adr;
  logic [ROW_BITS-1:0] e_row;
  logic [WIDTH-1:0]    mem_word;
  logic                mem_perr;
  logic [WIDTH-1:0]    fwd_word;
  logic                fwd_hit;
  logic [WIDTH-1:0]    wr_word;
  logic [ROW_BITS-1:0] wa_row;
  logic [PHY_W-1:0]    wa_bw;
  logic [PHY_W-1:0]    wa_data;

  always_comb begin
    iss_op  = OP_IDLE;
    iss_adr = ct_adr;
    iss_val = imm;
    if (clearing) begin
      iss_op = OP_IDLE;
    end else if (host_wr) begin
      iss_op  = OP_HWR;
      iss_adr = host_adr;
      iss_val = IS_FIRST ? host_din : '0;  // Other banks hold zero after a write
    end else if (host_rd) begin
      iss_op  = OP_HRD;
      iss_adr = host_adr;
    end else if (cnt) begin
      iss_op = OP_COUNT;
    end
  end

  assign bank_read   = (iss_op == OP_HRD) || (iss_op == OP_COUNT);
  assign bank_rd_adr = ROW_BITS'(iss_adr / NUMWRDS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i <= SRAM_DELAY; i++) begin
        s_op[i]  <= OP_IDLE;
        h_vld[i] <= 1'b0;
      end
    end else begin
      s_op[1]  <= iss_op;
      h_vld[1] <= bank_write;
      for (int i = 2; i <= SRAM_DELAY; i++) begin
        s_op[i]  <= s_op[i-1];
        h_vld[i] <= h_vld[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    s_adr[1]  <= iss_adr;
    s_val[1]  <= iss_val;
    h_clr[1]  <= clearing;
    h_adr[1]  <= e_adr;
    h_row[1]  <= bank_wr_adr;
    h_data[1] <= clearing ? '0 : wr_word;
    for (int i = 2; i <= SRAM_DELAY; i++) begin
      s_adr[i]  <= s_adr[i-1];
      s_val[i]  <= s_val[i-1];
      h_clr[i]  <= h_clr[i-1];
      h_adr[i]  <= h_adr[i-1];
      h_row[i]  <= h_row[i-1];
      h_data[i] <= h_data[i-1];
    end
  end

  assign e_op  = s_op[SRAM_DELAY];
  assign e_adr = s_adr[SRAM_DELAY];

  word_align #(
    .WIDTH   (WIDTH),
    .NUMWRDS (NUMWRDS),
    .NUMSROW (NUMSROW)
  ) word_align_rd_i (
    .adr      (e_adr),
    .wdata    ('0),
    .row_data (bank_dout),
    .row      (e_row),
    .bw       (),
    .wrow     (),
    .rword    (mem_word),
    .perr     (mem_perr)
  );

  // Newest matching write overrides the stored word
  always_comb begin
    fwd_hit  = 1'b0;
    fwd_word = mem_word;
    for (int k = SRAM_DELAY; k >= 1; k--) begin
      if (h_vld[k] && (h_clr[k] ? (h_row[k] == e_row) : (h_adr[k] == e_adr))) begin
        fwd_hit  = 1'b1;
        fwd_word = h_data[k];
      end
    end
  end

  assign wr_word = (e_op == OP_COUNT) ? fwd_word + s_val[SRAM_DELAY] : s_val[SRAM_DELAY];

  word_align #(
    .WIDTH   (WIDTH),
    .NUMWRDS (NUMWRDS),
    .NUMSROW (NUMSROW)
  ) word_align_wr_i (
    .adr      (e_adr),
    .wdata    (wr_word),
    .row_data ('0),
    .row      (wa_row),
    .bw       (wa_bw),
    .wrow     (wa_data),
    .rword    (),
    .perr     ()
  );

  always_comb begin
    bank_write  = 1'b0;
    bank_wr_adr = wa_row;
    bank_bw     = wa_bw;
    bank_din    = wa_data;
    if (clearing) begin
      bank_write  = 1'b1;
      bank_wr_adr = clear_row;
      bank_bw     = '1;
      bank_din    = '0;  // Zero words carry zero parity
    end else if ((e_op == OP_COUNT) || (e_op == OP_HWR)) begin
      bank_write = 1'b1;
    end
  end

  assign part_word = fwd_word;
  assign part_serr = (e_op == OP_HRD) && !fwd_hit && mem_perr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ct_vld  <= 1'b0;
      ct_serr <= 1'b0;
    end else begin
      ct_vld  <= (e_op == OP_COUNT);
      ct_serr <= (e_op == OP_COUNT) && !fwd_hit && mem_perr;
    end
  end

endmodule

`default_nettype wire

/* rtl/host_port.sv */
`default_nettype none
`timescale 1ns/1ps

module host_port import cntmem_pkg::*; #(
  parameter int WIDTH = 16,
  parameter int NUMCTPT = 4,
  parameter int NUMWRDS = 4,
  parameter int NUMSROW = 64,
  parameter int SRAM_DELAY = 2,
  localparam int ADR_BITS = bits_for(NUMWRDS * NUMSROW),
  localparam int ROW_BITS = bits_for(NUMSROW)
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     read,
  input  logic                     write,
  input  logic [ADR_BITS-1:0]      addr,
  input  logic [WIDTH-1:0]         din,
  input  logic [NUMCTPT*WIDTH-1:0] part_word,
  input  logic [NUMCTPT-1:0]       part_serr,
  output logic                     ready,
  output logic                     host_rd,
  output logic                     host_wr,
  output logic [ADR_BITS-1:0]      host_adr,
  output logic [WIDTH-1:0]         host_din,
  output logic [ROW_BITS-1:0]      clear_row,
  output logic                     clearing,
  output logic                     rd_vld,
  output logic [WIDTH-1:0]         rd_dout,
  output logic                     rd_serr
);

  host_state_t         state;
  logic [ROW_BITS-1:0] clr_cnt;
  bank_op_t            tag [1:SRAM_DELAY];
  logic [WIDTH-1:0]    sum;
  logic                serr_any;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_CLEAR;
      clr_cnt <= '0;
    end else begin
      case (state)
        ST_CLEAR: begin
          clr_cnt <= clr_cnt + 1'b1;
          if (clr_cnt == ROW_BITS'(NUMSROW - 1)) begin
            state <= ST_RUN;
          end
        end
        default: state <= ST_RUN;
      endcase
    end
  end

  assign ready     = (state == ST_RUN);
  assign clearing  = (state == ST_CLEAR);
  assign clear_row = clr_cnt;

  // Write wins when both strobes are high
  assign host_wr  = write && ready;
  assign host_rd  = read && ready && !write;
  assign host_adr = addr;
  assign host_din = din;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i <= SRAM_DELAY; i++) begin
        tag[i] <= OP_IDLE;
      end
    end else begin
      tag[1] <= host_rd ? OP_HRD : OP_IDLE;
      for (int i = 2; i <= SRAM_DELAY; i++) begin
        tag[i] <= tag[i-1];
      end
    end
  end

  // Partial sums wrap modulo 2**WIDTH
  always_comb begin
    sum      = '0;
    serr_any = 1'b0;
    for (int p = 0; p < NUMCTPT; p++) begin
      sum      = sum + part_word[p*WIDTH +: WIDTH];
      serr_any = serr_any | part_serr[p];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld  <= 1'b0;
      rd_serr <= 1'b0;
    end else begin
      rd_vld  <= (tag[SRAM_DELAY] == OP_HRD);
      rd_serr <= (tag[SRAM_DELAY] == OP_HRD) && serr_any;
    end
  end

  always_ff @(posedge clk) begin
    if (tag[SRAM_DELAY] == OP_HRD) begin
      rd_dout <= sum;
    end
  end

endmodule

`default_nettype wire

/* rtl/counter_mem_top.sv */
`default_nettype none
`timescale 1ns/1ps

module counter_mem_top import cntmem_pkg::*; #(
  parameter int WIDTH = 16,
  parameter int NUMCTPT = 4,
  parameter int NUMWRDS = 4,
  parameter int NUMSROW = 64,
  parameter int SRAM_DELAY = 2,
  localparam int ADR_BITS = bits_for(NUMWRDS * NUMSROW),
  localparam int ROW_BITS = bits_for(NUMSROW),
  localparam int PHY_W = row_width(WIDTH, NUMWRDS)
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [NUMCTPT-1:0]          cnt,
  input  logic [NUMCTPT*ADR_BITS-1:0] ct_adr,
  input  logic [NUMCTPT*WIDTH-1:0]    imm,
  output logic [NUMCTPT-1:0]          ct_vld,
  output logic [NUMCTPT-1:0]          ct_serr,
  input  logic                        read,
  input  logic                        write,
  input  logic [ADR_BITS-1:0]         addr,
  input  logic [WIDTH-1:0]            din,
  output logic                        rd_vld,
  output logic [WIDTH-1:0]            rd_dout,
  output logic                        rd_serr,
  output logic                        ready,
  output logic [NUMCTPT-1:0]          bank_write,
  output logic [NUMCTPT*ROW_BITS-1:0] bank_wr_adr,
  output logic [NUMCTPT*PHY_W-1:0]    bank_bw,
  output logic [NUMCTPT*PHY_W-1:0]    bank_din,
  output logic [NUMCTPT-1:0]          bank_read,
  output logic [NUMCTPT*ROW_BITS-1:0] bank_rd_adr,
  input  logic [NUMCTPT*PHY_W-1:0]    bank_dout
);

  logic                     host_rd;
  logic                     host_wr;
  logic [ADR_BITS-1:0]      host_adr;
  logic [WIDTH-1:0]         host_din;
  logic [ROW_BITS-1:0]      clear_row;
  logic                     clearing;
  logic [NUMCTPT*WIDTH-1:0] part_word;
  logic [NUMCTPT-1:0]       part_serr;

  host_port #(
    .WIDTH      (WIDTH),
    .NUMCTPT    (NUMCTPT),
    .NUMWRDS    (NUMWRDS),
    .NUMSROW    (NUMSROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) host_port_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .read      (read),
    .write     (write),
    .addr      (addr),
    .din       (din),
    .part_word (part_word),
    .part_serr (part_serr),
    .ready     (ready),
    .host_rd   (host_rd),
    .host_wr   (host_wr),
    .host_adr  (host_adr),
    .host_din  (host_din),
    .clear_row (clear_row),
    .clearing  (clearing),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_serr   (rd_serr)
  );

  for (genvar p = 0; p < NUMCTPT; p++) begin : g_bank
    counter_bank #(
      .WIDTH      (WIDTH),
      .NUMWRDS    (NUMWRDS),
      .NUMSROW    (NUMSROW),
      .SRAM_DELAY (SRAM_DELAY),
      .IS_FIRST   (p == 0)
    ) counter_bank_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .cnt         (cnt[p]),
      .ct_adr      (ct_adr[p*ADR_BITS +: ADR_BITS]),
      .imm         (imm[p*WIDTH +: WIDTH]),
      .host_rd     (host_rd),
      .host_wr     (host_wr),
      .host_adr    (host_adr),
      .host_din    (host_din),
      .clear_row   (clear_row),
      .clearing    (clearing),
      .bank_dout   (bank_dout[p*PHY_W +: PHY_W]),
      .ct_vld      (ct_vld[p]),
      .ct_serr     (ct_serr[p]),
      .part_word   (part_word[p*WIDTH +: WIDTH]),
      .part_serr   (part_serr[p]),
      .bank_write  (bank_write[p]),
      .bank_wr_adr (bank_wr_adr[p*ROW_BITS +: ROW_BITS]),
      .bank_bw     (bank_bw[p*PHY_W +: PHY_W]),
      .bank_din    (bank_din[p*PHY_W +: PHY_W]),
      .bank_read   (bank_read[p]),
      .bank_rd_adr (bank_rd_adr[p*ROW_BITS +: ROW_BITS])
    );
  end

endmodule

`default_nettype wire

/* tests/sram_1r1w_model.sv */
`default_nettype none
`timescale 1ns/1ps

module sram_1r1w_model import cntmem_pkg::*; #(
  parameter int WIDTH = 16,
  parameter int NUMWRDS = 4,
  parameter int NUMSROW = 64,
  parameter int SRAM_DELAY = 2,
  localparam int ROW_BITS = bits_for(NUMSROW),
  localparam int MEM_W = WIDTH + 1,
  localparam int PHY_W = row_width(WIDTH, NUMWRDS)
) (
  input  logic                clk,
  input  logic                write,
  input  logic [ROW_BITS-1:0] wr_adr,
  input  logic [PHY_W-1:0]    bw,
  input  logic [PHY_W-1:0]    din,
  input  logic                read,
  input  logic [ROW_BITS-1:0] rd_adr,
  output logic [PHY_W-1:0]    dout
);

  logic [PHY_W-1:0] mem  [NUMSROW];
  logic [PHY_W-1:0] pipe [1:SRAM_DELAY];

  always @(posedge clk) begin
    if (read) begin
      pipe[1] <= mem[rd_adr];  // Old data on a same-row write
    end
    for (int i = 2; i <= SRAM_DELAY; i++) begin
      pipe[i] <= pipe[i-1];
    end
    if (write) begin
      mem[wr_adr] <= (mem[wr_adr] & ~bw) | (din & bw);  // Bit-write mask
    end
  end

  assign dout = pipe[SRAM_DELAY];

  // Inverts the parity bit of one counter word
  task automatic flip_parity(input int adr);
    int row;
    int pos;
    row = adr / NUMWRDS;
    pos = (adr % NUMWRDS) * MEM_W + WIDTH;
    mem[row][pos] <= ~mem[row][pos];
  endtask

  function automatic logic parity_bad(input int adr);
    logic [MEM_W-1:0] slot;
    slot = MEM_W'(mem[adr / NUMWRDS] >> ((adr % NUMWRDS) * MEM_W));
    return word_parity(PAR_MAX'(slot[WIDTH-1:0])) != slot[WIDTH];
  endfunction

endmodule

`default_nettype wire

/* tests/counter_mem_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module counter_mem_tb import cntmem_pkg::*;;

  localparam int WIDTH = 16;
  localparam int NUMCTPT = 4;
  localparam int NUMWRDS = 4;
  localparam int NUMSROW = 64;
  localparam int SRAM_DELAY = 2;
  localparam int ADR_BITS = bits_for(NUMWRDS * NUMSROW);
  localparam int ROW_BITS = bits_for(NUMSROW);
  localparam int PHY_W = row_width(WIDTH, NUMWRDS);
  localparam int NADR = NUMWRDS * NUMSROW;
  localparam int CLK_HALF = 2;
  localparam int RST_CYC = 10;
  localparam int N_WR = 150;
  localparam int N_CNT = 300;
  localparam int N_MIX = 300;
  localparam int HOT_BASE = 32;  // Four hot counters share one row
  localparam int TOTAL_CYC = RST_CYC + NUMSROW + 3 * NADR + 2 * N_WR + N_CNT + N_MIX + 100;
  localparam int MARGIN = 500;

  logic                        clk;
  logic                        arst_n;
  logic [NUMCTPT-1:0]          cnt;
  logic [NUMCTPT*ADR_BITS-1:0] ct_adr;
  logic [NUMCTPT*WIDTH-1:0]    imm;
  logic [NUMCTPT-1:0]          ct_vld;
  logic [NUMCTPT-1:0]          ct_serr;
  logic                        read;
  logic                        write;
  logic [ADR_BITS-1:0]         addr;
  logic [WIDTH-1:0]            din;
  logic                        rd_vld;
  logic [WIDTH-1:0]            rd_dout;
  logic                        rd_serr;
  logic                        ready;
  logic [NUMCTPT-1:0]          bank_write;
  logic [NUMCTPT*ROW_BITS-1:0] bank_wr_adr;
  logic [NUMCTPT*PHY_W-1:0]    bank_bw;
  logic [NUMCTPT*PHY_W-1:0]    bank_din;
  logic [NUMCTPT-1:0]          bank_read;
  logic [NUMCTPT*ROW_BITS-1:0] bank_rd_adr;
  logic [NUMCTPT*PHY_W-1:0]    bank_dout;

  integer            seed;
  int                cyc;
  int                val_errs;
  int                pulse_errs;
  int                other_errs;
  string             test_name;
  logic [WIDTH-1:0]  ref_mem [NADR];
  logic              bad [NUMCTPT][NADR];  // Words whose parity the model corrupted

  int                rd_q_cyc  [$];
  logic [WIDTH-1:0]  rd_q_data [$];
  logic              rd_q_serr [$];
  int                rd_q_adr  [$];
  string             rd_q_test [$];
  int                ct_q_cyc  [$];
  int                ct_q_port [$];
  logic              ct_q_serr [$];
  string             ct_q_test [$];

  counter_mem_top #(
    .WIDTH      (WIDTH),
    .NUMCTPT    (NUMCTPT),
    .NUMWRDS    (NUMWRDS),
    .NUMSROW    (NUMSROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) counter_mem_top_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cnt         (cnt),
    .ct_adr      (ct_adr),
    .imm         (imm),
    .ct_vld      (ct_vld),
    .ct_serr     (ct_serr),
    .read        (read),
    .write       (write),
    .addr        (addr),
    .din         (din),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .rd_serr     (rd_serr),
    .ready       (ready),
    .bank_write  (bank_write),
    .bank_wr_adr (bank_wr_adr),
    .bank_bw     (bank_bw),
    .bank_din    (bank_din),
    .bank_read   (bank_read),
    .bank_rd_adr (bank_rd_adr),
    .bank_dout   (bank_dout)
  );

  for (genvar p = 0; p < NUMCTPT; p++) begin : g_sram
    sram_1r1w_model #(
      .WIDTH      (WIDTH),
      .NUMWRDS    (NUMWRDS),
      .NUMSROW    (NUMSROW),
      .SRAM_DELAY (SRAM_DELAY)
    ) sram_1r1w_model_i (
      .clk    (clk),
      .write  (bank_write[p]),
      .wr_adr (bank_wr_adr[p*ROW_BITS +: ROW_BITS]),
      .bw     (bank_bw[p*PHY_W +: PHY_W]),
      .din    (bank_din[p*PHY_W +: PHY_W]),
      .read   (bank_read[p]),
      .rd_adr (bank_rd_adr[p*ROW_BITS +: ROW_BITS]),
      .dout   (bank_dout[p*PHY_W +: PHY_W])
    );
  end

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // Applies one cycle of inputs to the reference counters and queues the expected results
  function automatic void ref_apply();
    logic [ADR_BITS-1:0] a;
    logic                any_bad;
    if (write) begin
      ref_mem[addr] = din;
      for (int b = 0; b < NUMCTPT; b++) bad[b][addr] = 1'b0;
    end else if (read) begin
      any_bad = 1'b0;
      for (int b = 0; b < NUMCTPT; b++) any_bad = any_bad | bad[b][addr];
      rd_q_cyc.push_back(cyc + SRAM_DELAY + 1);
      rd_q_data.push_back(ref_mem[addr]);
      rd_q_serr.push_back(any_bad);
      rd_q_adr.push_back(addr);
      rd_q_test.push_back(test_name);
    end else begin
      for (int p = 0; p < NUMCTPT; p++) begin
        if (cnt[p]) begin
          a = ct_adr[p*ADR_BITS +: ADR_BITS];
          ref_mem[a] = ref_mem[a] + imm[p*WIDTH +: WIDTH];
          ct_q_cyc.push_back(cyc + SRAM_DELAY + 1);
          ct_q_port.push_back(p);
          ct_q_serr.push_back(bad[p][a]);
          ct_q_test.push_back(test_name);
          bad[p][a] = 1'b0;  // Write-back restores parity
        end
      end
    end
  endfunction

  function automatic logic [ADR_BITS-1:0] pick_addr();
    if (($random(seed) & 1) == 1) begin
      return ADR_BITS'(HOT_BASE + ($random(seed) & 3));
    end
    return ADR_BITS'($random(seed));
  endfunction

  task automatic drive_cycle(input logic rd, input logic wr, input logic [ADR_BITS-1:0] a,
                             input logic [WIDTH-1:0] d, input logic [NUMCTPT-1:0] c,
                             input logic [NUMCTPT*ADR_BITS-1:0] ca,
                             input logic [NUMCTPT*WIDTH-1:0] ci);
    @(posedge clk);
    #1;
    read   = rd;
    write  = wr;
    addr   = a;
    din    = d;
    cnt    = c;
    ct_adr = ca;
    imm    = ci;
    ref_apply();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, '0, '0, '0, '0, '0);
  endtask

  task automatic read_all();
    for (int a = 0; a < NADR; a++) drive_cycle(1'b1, 1'b0, ADR_BITS'(a), '0, '0, '0, '0);
  endtask

  task automatic make_counts(output logic [NUMCTPT-1:0] c,
                             output logic [NUMCTPT*ADR_BITS-1:0] ca,
                             output logic [NUMCTPT*WIDTH-1:0] ci);
    for (int p = 0; p < NUMCTPT; p++) begin
      c[p] = ($random(seed) & 3) != 0;
      ca[p*ADR_BITS +: ADR_BITS] = pick_addr();
      ci[p*WIDTH +: WIDTH] = WIDTH'($random(seed));
    end
  endtask

  task automatic wait_ready(output bit ok, output int n);
    ok = 1'b0;
    n = 0;
    while (!ok && n < NUMSROW + 20) begin
      @(posedge clk);
      #1;
      ok = ready;
      n++;
    end
  endtask

  task automatic wait_drained(output bit ok);
    int n;
    n = 0;
    while ((rd_q_cyc.size() > 0 || ct_q_cyc.size() > 0) && n < SRAM_DELAY + 10) begin
      @(posedge clk);
      n++;
    end
    ok = (rd_q_cyc.size() == 0) && (ct_q_cyc.size() == 0);
  endtask

  task automatic pop_read();
    int               i;
    logic             b;
    logic [WIDTH-1:0] w;
    string            s;
    i = rd_q_cyc.pop_front();
    w = rd_q_data.pop_front();
    b = rd_q_serr.pop_front();
    i = rd_q_adr.pop_front();
    s = rd_q_test.pop_front();
  endtask

  task automatic pop_count();
    int    i;
    logic  b;
    string s;
    i = ct_q_cyc.pop_front();
    i = ct_q_port.pop_front();
    b = ct_q_serr.pop_front();
    s = ct_q_test.pop_front();
  endtask

  // Outputs are sampled at the falling edge half a cycle after they change
  always @(negedge clk) begin
    if (arst_n) begin
      while (rd_q_cyc.size() > 0 && rd_q_cyc[0] < cyc) begin
        $display("No rd_vld for %s read of address %0h due at cycle %0d",
                 rd_q_test[0], rd_q_adr[0], rd_q_cyc[0]);
        pulse_errs++;
        pop_read();
      end
      if (rd_vld) begin
        if (rd_q_cyc.size() == 0) begin
          $display("Unexpected rd_vld pulse at cycle %0d", cyc);
          pulse_errs++;
        end else begin
          if (rd_q_cyc[0] != cyc) begin
            $display("rd_vld at cycle %0d, expected at cycle %0d", cyc, rd_q_cyc[0]);
            pulse_errs++;
          end
          if (rd_dout !== rd_q_data[0]) begin
            $display("ERR %s rd_dout at %0h: expected %0h actual %0h",
                     rd_q_test[0], rd_q_adr[0], rd_q_data[0], rd_dout);
            val_errs++;
          end
          if (rd_serr !== rd_q_serr[0]) begin
            $display("ERR %s rd_serr at %0h: expected %0b actual %0b",
                     rd_q_test[0], rd_q_adr[0], rd_q_serr[0], rd_serr);
            val_errs++;
          end
          pop_read();
        end
      end
      while (ct_q_cyc.size() > 0 && ct_q_cyc[0] < cyc) begin
        $display("No ct_vld on port %0d for %s count due at cycle %0d",
                 ct_q_port[0], ct_q_test[0], ct_q_cyc[0]);
        pulse_errs++;
        pop_count();
      end
      for (int p = 0; p < NUMCTPT; p++) begin
        if (ct_vld[p]) begin
          if (ct_q_cyc.size() == 0) begin
            $display("Unexpected ct_vld pulse on port %0d at cycle %0d", p, cyc);
            pulse_errs++;
          end else begin
            if (ct_q_cyc[0] != cyc || ct_q_port[0] != p) begin
              $display("ct_vld on port %0d at cycle %0d, expected port %0d at cycle %0d",
                       p, cyc, ct_q_port[0], ct_q_cyc[0]);
              pulse_errs++;
            end
            if (ct_serr[p] !== ct_q_serr[0]) begin
              $display("ERR %s ct_serr port %0d: expected %0b actual %0b",
                       ct_q_test[0], p, ct_q_serr[0], ct_serr[p]);
              val_errs++;
            end
            pop_count();
          end
        end
      end
    end
  end

  initial begin
    #(2 * CLK_HALF * (TOTAL_CYC + MARGIN));
    $display("Watchdog expired after %0d cycles, the run did not complete", TOTAL_CYC + MARGIN);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    bit                          ok;
    int                          n;
    int                          op;
    logic [NUMCTPT-1:0]          c;
    logic [NUMCTPT*ADR_BITS-1:0] ca;
    logic [NUMCTPT*WIDTH-1:0]    ci;
    logic [ADR_BITS-1:0]         a;
    logic [ADR_BITS-1:0]         a1;
    logic [ADR_BITS-1:0]         a3;
    logic [WIDTH-1:0]            d;
    clk = 1'b0;
    arst_n = 1'b0;
    cnt = '0;
    ct_adr = '0;
    imm = '0;
    read = 1'b0;
    write = 1'b0;
    addr = '0;
    din = '0;
    seed = 32'h60fd;
    cyc = 0;
    val_errs = 0;
    pulse_errs = 0;
    other_errs = 0;
    test_name = "clear";
    for (int i = 0; i < NADR; i++) begin
      ref_mem[i] = '0;
      for (int b = 0; b < NUMCTPT; b++) bad[b][i] = 1'b0;
    end
    repeat (RST_CYC) @(posedge clk);
    if (rd_vld !== 1'b0 || ct_vld !== '0) begin
      $display("Valid outputs are not low during reset");
      other_errs++;
    end
    #1 arst_n = 1'b1;
    wait_ready(ok, n);
    if (ok) begin
      if (n < NUMSROW) begin
        $display("ready rose after %0d cycles, before the clear sweep ended", n);
        other_errs++;
      end
      read_all();  // Every counter is zero after clearing

      test_name = "write_read";
      for (int i = 0; i < N_WR; i++) begin
        a = ADR_BITS'($random(seed));
        d = WIDTH'($random(seed));
        drive_cycle(1'b0, 1'b1, a, d, '0, '0, '0);
        drive_cycle(1'b1, 1'b0, a, '0, '0, '0, '0);
      end

      test_name = "counts";
      for (int i = 0; i < N_CNT; i++) begin
        make_counts(c, ca, ci);
        drive_cycle(1'b0, 1'b0, '0, '0, c, ca, ci);
      end
      idle_cycles(SRAM_DELAY + 2);
      read_all();

      test_name = "ignored_counts";
      for (int i = 0; i < N_MIX; i++) begin
        make_counts(c, ca, ci);
        op = $random(seed) & 3;
        a = pick_addr();
        d = WIDTH'($random(seed));
        drive_cycle(op == 0, op == 1, a, d, c, ca, ci);
      end
      idle_cycles(SRAM_DELAY + 2);
      read_all();

      test_name = "parity";
      idle_cycles(SRAM_DELAY + 2);
      a1 = ADR_BITS'($random(seed));
      a3 = a1 ^ ADR_BITS'(NUMWRDS * 8);  // Another row
      g_sram[1].sram_1r1w_model_i.flip_parity(a1);
      bad[1][a1] = 1'b1;
      g_sram[0].sram_1r1w_model_i.flip_parity(a3);
      bad[0][a3] = 1'b1;
      idle_cycles(1);
      if (!g_sram[1].sram_1r1w_model_i.parity_bad(a1) ||
          !g_sram[0].sram_1r1w_model_i.parity_bad(a3)) begin
        $display("SRAM model did not corrupt the parity of the chosen words");
        other_errs++;
      end
      drive_cycle(1'b1, 1'b0, a1, '0, '0, '0, '0);
      drive_cycle(1'b1, 1'b0, a1 ^ ADR_BITS'(1), '0, '0, '0, '0);  // Clean word in the same row
      idle_cycles(SRAM_DELAY + 2);
      ca = {NUMCTPT{a1}};
      ca[0 +: ADR_BITS] = a3;
      drive_cycle(1'b0, 1'b0, '0, '0, 4'b0011, ca, {NUMCTPT{16'h0005}});
      idle_cycles(SRAM_DELAY + 2);
      drive_cycle(1'b1, 1'b0, a1, '0, '0, '0, '0);
      drive_cycle(1'b1, 1'b0, a3, '0, '0, '0, '0);
      idle_cycles(SRAM_DELAY + 2);
    end else begin
      $display("ready did not rise within %0d cycles after reset", n);
      other_errs++;
    end
    wait_drained(ok);
    if (!ok) begin
      $display("Results still outstanding at the end of the run");
      other_errs++;
    end
    $display("Checks done: %0d value errors, %0d pulse errors, %0d other errors",
             val_errs, pulse_errs, other_errs);
    if (val_errs + pulse_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/cntmem_pkg.sv
rtl/word_align.sv
rtl/counter_bank.sv
rtl/host_port.sv
rtl/counter_mem_top.sv
tests/sram_1r1w_model.sv
tests/counter_mem_tb.sv

/* Bender.yml */
package:
  name: counter_mem

sources:
  - rtl/cntmem_pkg.sv
  - rtl/word_align.sv
  - rtl/counter_bank.sv
  - rtl/host_port.sv
  - rtl/counter_mem_top.sv
  - target: test
    files:
      - tests/sram_1r1w_model.sv
      - tests/counter_mem_tb.sv
